// ==== hw/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int shamt_w    = 5;
    localparam int opcode_w   = 7;
    localparam int funct3_w   = 3;
    localparam int funct7_w   = 7;
    localparam int strb_w     = 4;

    localparam logic [opcode_w-1:0] op_reg    = 7'b0110011;
    localparam logic [opcode_w-1:0] op_imm    = 7'b0010011;
    localparam logic [opcode_w-1:0] op_lui    = 7'b0110111;
    localparam logic [opcode_w-1:0] op_auipc  = 7'b0010111;
    localparam logic [opcode_w-1:0] op_jal    = 7'b1101111;
    localparam logic [opcode_w-1:0] op_jalr   = 7'b1100111;
    localparam logic [opcode_w-1:0] op_branch = 7'b1100011;
    localparam logic [opcode_w-1:0] op_load   = 7'b0000011;
    localparam logic [opcode_w-1:0] op_store  = 7'b0100011;

    localparam logic [funct3_w-1:0] f3_add  = 3'b000;  // also sub
    localparam logic [funct3_w-1:0] f3_sll  = 3'b001;
    localparam logic [funct3_w-1:0] f3_slt  = 3'b010;
    localparam logic [funct3_w-1:0] f3_sltu = 3'b011;
    localparam logic [funct3_w-1:0] f3_xor  = 3'b100;
    localparam logic [funct3_w-1:0] f3_sr   = 3'b101;  // srl / sra
    localparam logic [funct3_w-1:0] f3_or   = 3'b110;
    localparam logic [funct3_w-1:0] f3_and  = 3'b111;

    localparam logic [funct3_w-1:0] f3_beq  = 3'b000;
    localparam logic [funct3_w-1:0] f3_bne  = 3'b001;
    localparam logic [funct3_w-1:0] f3_blt  = 3'b100;
    localparam logic [funct3_w-1:0] f3_bge  = 3'b101;
    localparam logic [funct3_w-1:0] f3_bltu = 3'b110;
    localparam logic [funct3_w-1:0] f3_bgeu = 3'b111;

    localparam logic [funct3_w-1:0] f3_byte   = 3'b000;
    localparam logic [funct3_w-1:0] f3_half   = 3'b001;
    localparam logic [funct3_w-1:0] f3_word   = 3'b010;
    localparam logic [funct3_w-1:0] f3_byte_u = 3'b100;
    localparam logic [funct3_w-1:0] f3_half_u = 3'b101;

    localparam logic [funct7_w-1:0] f7_alt = 7'b0100000;  // sub, sra

    localparam logic [strb_w-1:0] strb_byte = 4'b0001;
    localparam logic [strb_w-1:0] strb_half = 4'b0011;
    localparam logic [strb_w-1:0] strb_word = 4'b1111;

endpackage

`default_nettype wire

// ==== hw/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

    import rv_isa_pkg::*;

    // imm arrives sign-extended from decode, lui/auipc with low 12 bits zero
    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [opcode_w-1:0]   opcode;
        logic [funct3_w-1:0]   funct3;
        logic [funct7_w-1:0]   funct7;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       rs1_data;
        logic [xlen-1:0]       rs2_data;
        logic [xlen-1:0]       imm;
    } issue_t;

    typedef struct packed {
        logic                  valid;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
    } reg_wb_t;

    typedef struct packed {
        logic                  load;
        logic                  store;
        logic [reg_addr_w-1:0] rd;         // loads only
        logic [xlen-1:0]       addr;
        logic [strb_w-1:0]     strb;
        logic                  is_signed;  // sign-extend loaded data
        logic [xlen-1:0]       wdata;      // stores only
    } mem_req_t;

    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
    } jump_t;

    typedef struct packed {
        reg_wb_t  wb;
        mem_req_t mem;
        jump_t    jmp;
    } exec_result_t;

endpackage

`default_nettype wire

// ==== hw/exec_issue_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_issue_reg (
    input  logic             CLK,
    input  logic             rst_n,
    input  logic             flush,
    input  logic             in_valid,
    output logic             in_ready,
    input  exec_pkg::issue_t in,
    output logic             out_valid,
    input  logic             out_ready,
    output exec_pkg::issue_t cur
);

    logic take;

    // free slot, or the held one leaves this edge
    assign in_ready = !out_valid || out_ready;
    assign take     = in_valid && in_ready && !flush;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;  // drop held and incoming
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (take) begin
            cur <= in;
        end
    end

    // held instruction must not change under back-pressure
    hold_stable: assert property (
        @(posedge CLK) disable iff (!rst_n)
        out_valid && !out_ready |=> $stable(cur)
    ) else $error("exec_issue_reg: held instruction changed while stalled");

endmodule

`default_nettype wire

// ==== hw/int_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module int_alu (
    input  exec_pkg::issue_t  cur,
    output exec_pkg::reg_wb_t wb
);

    import rv_isa_pkg::*;

    logic [xlen-1:0]    opb;
    logic [shamt_w-1:0] shamt;
    logic               alt;
    logic               is_sub;
    logic [xlen-1:0]    alu_res;

    assign opb    = (cur.opcode == op_reg) ? cur.rs2_data : cur.imm;
    assign shamt  = opb[shamt_w-1:0];
    assign alt    = (cur.funct7 == f7_alt);
    assign is_sub = alt && (cur.opcode == op_reg);  // no subi

    always_comb begin
        case (cur.funct3)
            f3_add:  alu_res = is_sub ? cur.rs1_data - opb : cur.rs1_data + opb;
            f3_sll:  alu_res = cur.rs1_data << shamt;
            f3_slt:  alu_res = {{(xlen-1){1'b0}}, $signed(cur.rs1_data) < $signed(opb)};
            f3_sltu: alu_res = {{(xlen-1){1'b0}}, cur.rs1_data < opb};
            f3_xor:  alu_res = cur.rs1_data ^ opb;
            f3_sr: begin
                if (alt) begin
                    alu_res = $signed(cur.rs1_data) >>> shamt;
                end else begin
                    alu_res = cur.rs1_data >> shamt;
                end
            end
            f3_or:   alu_res = cur.rs1_data | opb;
            f3_and:  alu_res = cur.rs1_data & opb;
            default: alu_res = '0;
        endcase
    end

    always_comb begin
        wb.valid = 1'b1;
        wb.rd    = cur.rd;
        case (cur.opcode)
            op_reg, op_imm: wb.data = alu_res;
            op_lui:         wb.data = cur.imm;
            op_auipc:       wb.data = cur.pc + cur.imm;
            op_jal, op_jalr: wb.data = cur.pc + xlen'(4);  // link
            default: begin
                wb.valid = 1'b0;
                wb.rd    = '0;
                wb.data  = '0;
            end
        endcase
    end

    // funct3 comes straight from decode, X here means a broken upstream
    always_comb begin
        if (cur.opcode == op_reg) begin
            f3_known: assert final (!$isunknown(cur.funct3))
                else $error("int_alu: unknown funct3 on register op");
        end
    end

endmodule

`default_nettype wire

// ==== hw/mem_agu.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_agu (
    input  exec_pkg::issue_t   cur,
    output exec_pkg::mem_req_t req
);

    import rv_isa_pkg::*;

    logic            is_load;
    logic            is_store;
    logic [xlen-1:0] ea;

    assign is_load  = (cur.opcode == op_load);
    assign is_store = (cur.opcode == op_store);
    assign ea       = cur.rs1_data + cur.imm;

    always_comb begin
        req       = '0;
        req.load  = is_load;
        req.store = is_store;
        if (is_load || is_store) begin
            req.addr = ea;
            case (cur.funct3)
                f3_byte, f3_byte_u: req.strb = strb_byte;
                f3_half, f3_half_u: req.strb = strb_half;
                f3_word:            req.strb = strb_word;
                default:            req.strb = '0;
            endcase
        end
        if (is_load) begin
            req.rd        = cur.rd;
            req.is_signed = (cur.funct3 == f3_byte) || (cur.funct3 == f3_half);  // lw never
        end
        if (is_store) begin
            req.wdata = cur.rs2_data;
        end
    end

    always_comb begin
        ld_st_excl: assert final (!(req.load && req.store))
            else $error("mem_agu: load and store raised together");
    end

endmodule

`default_nettype wire

// ==== hw/branch_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module branch_unit (
    input  exec_pkg::issue_t cur,
    output exec_pkg::jump_t  jmp
);

    import rv_isa_pkg::*;

    logic [xlen-1:0] pc_rel;
    logic [xlen-1:0] reg_rel;
    logic            cond;

    assign pc_rel  = cur.pc + cur.imm;
    assign reg_rel = cur.rs1_data + cur.imm;

    always_comb begin
        case (cur.funct3)
            f3_beq:  cond = (cur.rs1_data == cur.rs2_data);
            f3_bne:  cond = (cur.rs1_data != cur.rs2_data);
            f3_blt:  cond = ($signed(cur.rs1_data) < $signed(cur.rs2_data));
            f3_bge:  cond = ($signed(cur.rs1_data) >= $signed(cur.rs2_data));
            f3_bltu: cond = (cur.rs1_data < cur.rs2_data);
            f3_bgeu: cond = (cur.rs1_data >= cur.rs2_data);
            default: cond = 1'b0;  // 010/011 reserved
        endcase
    end

    always_comb begin
        case (cur.opcode)
            op_branch: begin
                jmp.taken  = cond;
                jmp.target = pc_rel;
            end
            op_jal: begin
                jmp.taken  = 1'b1;
                jmp.target = pc_rel;
            end
            op_jalr: begin
                jmp.taken  = 1'b1;
                jmp.target = {reg_rel[xlen-1:1], 1'b0};  // lsb cleared
            end
            default: begin
                jmp.taken  = 1'b0;
                jmp.target = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/exec_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_top (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  logic                   flush,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  exec_pkg::issue_t       in,
    output logic                   out_valid,
    input  logic                   out_ready,
    output exec_pkg::exec_result_t out
);

    import exec_pkg::*;

    issue_t   cur;
    reg_wb_t  wb;
    mem_req_t req;
    jump_t    jmp;

    exec_issue_reg u_issue (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in        (in),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .cur       (cur)
    );

    int_alu     u_alu (.cur(cur), .wb(wb));
    mem_agu     u_agu (.cur(cur), .req(req));
    branch_unit u_bru (.cur(cur), .jmp(jmp));

    // validity rides on out_valid only
    assign out = '{wb: wb, mem: req, jmp: jmp};

endmodule

`default_nettype wire

// ==== bench/exec_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_checker (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  logic                   flush,
    input  logic                   in_valid,
    input  logic                   in_ready,
    input  logic                   out_valid,
    input  logic                   out_ready,
    input  exec_pkg::exec_result_t res,
    output int                     mismatches,
    output int                     checked,
    output int                     expected
);

    import exec_pkg::*;

    exec_result_t exp_q[$];
    logic         held;  // an accepted instruction waits on out

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("MISMATCH %0t: result %0d field %s is %h, expected %h",
                     $time, checked, name, got, want);
            mismatches++;
        end
    endtask

    // out_valid one edge after acceptance, in_ready free slot or leaving
    task automatic check_handshake();
        logic want_ready;
        want_ready = !held || out_ready;
        if (out_valid !== held) begin
            $display("MISMATCH %0t: out_valid is %b, expected %b", $time, out_valid, held);
            mismatches++;
        end
        if (in_ready !== want_ready) begin
            $display("MISMATCH %0t: in_ready is %b, expected %b", $time, in_ready, want_ready);
            mismatches++;
        end
    endtask

    initial begin
        int           fd;
        int           n;
        string        line;
        logic [31:0]  c [21];
        exec_result_t e;
        mismatches = 0;
        checked    = 0;
        expected   = 0;
        held       = 1'b0;
        fd = $fopen("bench/exec_cases.txt", "r");
        if (fd == 0) begin
            $display("checker could not open bench/exec_cases.txt");
            mismatches++;
        end else begin
            while ($fgets(line, fd)) begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            c[0], c[1], c[2], c[3], c[4], c[5], c[6], c[7], c[8], c[9],
                            c[10], c[11], c[12], c[13], c[14], c[15], c[16], c[17],
                            c[18], c[19], c[20]);
                if (n == 21 && !c[0][0]) begin  // flushed lines never come out
                    e.wb.valid      = c[9][0];
                    e.wb.rd         = c[10][4:0];
                    e.wb.data       = c[11];
                    e.mem.load      = c[12][0];
                    e.mem.store     = c[13][0];
                    e.mem.rd        = c[14][4:0];
                    e.mem.addr      = c[15];
                    e.mem.strb      = c[16][3:0];
                    e.mem.is_signed = c[17][0];
                    e.mem.wdata     = c[18];
                    e.jmp.taken     = c[19][0];
                    e.jmp.target    = c[20];
                    exp_q.push_back(e);
                end
            end
            $fclose(fd);
            expected = exp_q.size();
        end
    end

    // inputs settle after the rising edge, so sample on the falling one
    always @(negedge CLK) begin
        exec_result_t e;
        if (!rst_n) begin
            held = 1'b0;
        end else begin
            check_handshake();
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("%0t: a result came out after all expected ones", $time);
                    mismatches++;
                end else begin
                    e = exp_q.pop_front();
                    check_field("wb.valid", res.wb.valid, e.wb.valid);
                    check_field("wb.rd", res.wb.rd, e.wb.rd);
                    check_field("wb.data", res.wb.data, e.wb.data);
                    check_field("mem.load", res.mem.load, e.mem.load);
                    check_field("mem.store", res.mem.store, e.mem.store);
                    check_field("mem.rd", res.mem.rd, e.mem.rd);
                    check_field("mem.addr", res.mem.addr, e.mem.addr);
                    check_field("mem.strb", res.mem.strb, e.mem.strb);
                    check_field("mem.is_signed", res.mem.is_signed, e.mem.is_signed);
                    check_field("mem.wdata", res.mem.wdata, e.mem.wdata);
                    check_field("jmp.taken", res.jmp.taken, e.jmp.taken);
                    check_field("jmp.target", res.jmp.target, e.jmp.target);
                    checked++;
                end
            end
            held = !flush && ((held && !out_ready) || (in_valid && in_ready));  // after the edge
        end
    end

endmodule

`default_nettype wire

// ==== bench/exec_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_tb;

    import exec_pkg::*;

    localparam int max_wait = 200;

    logic         CLK;
    logic         rst_n;
    logic         flush;
    logic         in_valid;
    logic         in_ready;
    issue_t       in;
    logic         out_valid;
    logic         out_ready;
    exec_result_t out;

    logic         hold;  // keeps out_ready low around a flush
    logic [31:0]  rng;
    int           mismatches;
    int           checked;
    int           expected;
    int           stalls;
    issue_t       cases_q[$];
    logic         flush_q[$];

    exec_top uut (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in        (in),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out       (out)
    );

    exec_checker chk (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .flush      (flush),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .res        (out),
        .mismatches (mismatches),
        .checked    (checked),
        .expected   (expected)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // next edge, then new random out_ready
    task automatic tick();
        @(posedge CLK);
        #1;
        rng = xorshift(rng);
        out_ready = hold ? 1'b0 : (rng[1:0] != 2'b00);
    endtask

    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        logic [31:0] c [9];
        issue_t      ins;
        fd = $fopen("bench/exec_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/exec_cases.txt");
            return;
        end
        while ($fgets(line, fd)) begin
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                        c[0], c[1], c[2], c[3], c[4], c[5], c[6], c[7], c[8]);
            if (n == 9) begin  // comment lines do not parse
                ins.pc       = c[1];
                ins.opcode   = c[2][6:0];
                ins.funct3   = c[3][2:0];
                ins.funct7   = c[4][6:0];
                ins.rd       = c[5][4:0];
                ins.rs1_data = c[6];
                ins.rs2_data = c[7];
                ins.imm      = c[8];
                cases_q.push_back(ins);
                flush_q.push_back(c[0][0]);
            end
        end
        $fclose(fd);
    endtask

    task automatic send(input issue_t ins, input logic fl, output logic ok);
        int   gap;
        int   waited;
        logic acc;
        rng = xorshift(rng);
        gap = rng % 3;
        in_valid = 1'b0;
        repeat (gap) tick();  // idle cycles
        in       = ins;
        in_valid = 1'b1;
        acc      = 1'b0;
        waited   = 0;
        while (!acc && waited < max_wait) begin
            @(negedge CLK);
            acc = in_ready;  // taken at the coming edge
            tick();
            waited++;
        end
        in_valid = 1'b0;
        ok = acc;
        if (!acc) begin
            $display("stall: instruction at pc %h was never accepted", ins.pc);
            return;
        end
        if (fl) begin
            hold      = 1'b1;
            out_ready = 1'b0;
            flush     = 1'b1;
            tick();
            flush = 1'b0;
            hold  = 1'b0;
        end
    endtask

    task automatic run_cases();
        logic ok;
        foreach (cases_q[i]) begin
            send(cases_q[i], flush_q[i], ok);
            if (!ok) begin
                stalls++;
                return;
            end
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (checked < expected && waited < max_wait) begin
            tick();
            waited++;
        end
        if (checked < expected) begin
            $display("stall: only %0d of %0d results came out", checked, expected);
            stalls++;
        end
    endtask

    task automatic finish_run();
        $display("mismatches: %0d, stalls: %0d, results checked: %0d of %0d",
                 mismatches, stalls, checked, expected);
        if (mismatches == 0 && stalls == 0 && expected > 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    initial begin
        rst_n     = 1'b0;
        flush     = 1'b0;
        in_valid  = 1'b0;
        in        = '0;
        out_ready = 1'b0;
        hold      = 1'b0;
        rng       = 32'd58;
        stalls    = 0;
        load_cases();
        repeat (10) @(posedge CLK);
        #1;
        rst_n = 1'b1;
        run_cases();
        if (stalls == 0) begin
            drain();
        end
        finish_run();
    end

endmodule

`default_nettype wire

// ==== bench/exec_cases.txt ====
# fl pc op f3 f7 rd rs1 rs2 imm / wb: v rd data / mem: ld st rd addr strb sgn wdata / jmp: tk target
# all hex, fl=1 marks an instruction flushed while held, its expected columns are skipped
0 100 33 0 0 1 5 7 0  1 1 c  0 0 0 0 0 0 0  0 0
0 104 33 0 20 2 5 7 0  1 2 fffffffe  0 0 0 0 0 0 0  0 0
0 108 33 2 0 3 ffffffff 1 0  1 3 1  0 0 0 0 0 0 0  0 0
0 10c 33 3 0 4 ffffffff 1 0  1 4 0  0 0 0 0 0 0 0  0 0
0 110 33 5 20 5 80000000 4 0  1 5 f8000000  0 0 0 0 0 0 0  0 0
0 114 33 5 0 6 80000000 4 0  1 6 8000000  0 0 0 0 0 0 0  0 0
0 118 13 4 7f 7 ffff 0 ffffffff  1 7 ffff0000  0 0 0 0 0 0 0  0 0
0 11c 13 5 20 8 fffffff0 0 403  1 8 fffffffe  0 0 0 0 0 0 0  0 0
0 120 37 5 0 9 0 0 12345000  1 9 12345000  0 0 0 0 0 0 0  0 0
0 200 17 1 0 a 0 0 1000  1 a 1200  0 0 0 0 0 0 0  0 0
0 300 6f 0 0 1 0 0 fffffff0  1 1 304  0 0 0 0 0 0 0  1 2f0
0 400 67 0 0 1 1003 0 4  1 1 404  0 0 0 0 0 0 0  1 1006
0 500 63 0 0 0 8 8 20  0 0 0  0 0 0 0 0 0 0  1 520
0 504 63 1 0 0 8 8 20  0 0 0  0 0 0 0 0 0 0  0 524
0 600 63 4 0 0 ffffffff 1 ffffff00  0 0 0  0 0 0 0 0 0 0  1 500
0 604 63 6 0 0 ffffffff 1 ffffff00  0 0 0  0 0 0 0 0 0 0  0 504
0 700 63 5 0 0 1 ffffffff 8  0 0 0  0 0 0 0 0 0 0  1 708
0 704 63 7 0 0 1 ffffffff 8  0 0 0  0 0 0 0 0 0 0  0 70c
0 800 03 0 0 10 2000 0 fffffffc  0 0 0  1 0 10 1ffc 1 1 0  0 0
0 804 03 5 0 11 2000 0 6  0 0 0  1 0 11 2006 3 0 0  0 0
0 808 03 2 0 12 3000 0 0  0 0 0  1 0 12 3000 f 0 0  0 0
0 80c 23 2 0 10 4000 deadbeef 10  0 0 0  0 1 0 4010 f 0 deadbeef  0 0
0 810 23 0 0 1f 4000 ab ffffffff  0 0 0  0 1 0 3fff 1 0 ab  0 0
1 900 33 0 0 1 1 1 0  1 1 2  0 0 0 0 0 0 0  0 0
0 904 33 7 0 2 f0f0 ff 0  1 2 f0  0 0 0 0 0 0 0  0 0

// ==== project.f ====
hw/rv_isa_pkg.sv
hw/exec_pkg.sv
hw/exec_issue_reg.sv
hw/int_alu.sv
hw/mem_agu.sv
hw/branch_unit.sv
hw/exec_top.sv
bench/exec_checker.sv
bench/exec_tb.sv

// ==== Bender.yml ====
package:
  name: exec_stage

sources:
  - files:
      - hw/rv_isa_pkg.sv
      - hw/exec_pkg.sv
      - hw/exec_issue_reg.sv
      - hw/int_alu.sv
      - hw/mem_agu.sv
      - hw/branch_unit.sv
      - hw/exec_top.sv
  - target: test
    files:
      - bench/exec_checker.sv
      - bench/exec_tb.sv
